// File: hw/predist_pkg.sv
/*
 * shared widths, settings register map, reset values and unit-vector tables
 * for the polar predistorter; modules pull these in with a wildcard import
 */
`default_nettype none

package predist_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int SAMPLE_W       = 16;
  localparam int TAP_COUNT      = 16;
  localparam int TAP_IDX_W      = 4;
  localparam int SET_ADDR_W     = 8;
  localparam int SET_DATA_W     = 32;

  // gain is u4.12, so 4096 means unity
  localparam int GAIN_FRAC_BITS = 12;
  // unit vector is scaled to UNIT_ONE, product shifted back by this much
  localparam int COMBINE_SHIFT  = 15;
  localparam int UNIT_ONE       = 16383;

  typedef logic        [SAMPLE_W-1:0] sample_t;
  typedef logic signed [SAMPLE_W-1:0] iq_t;

  // ----------------------------------------
  // settings register map
  // ----------------------------------------
  // taps occupy SR_TAP_BASE .. SR_TAP_BASE + TAP_COUNT - 1
  typedef enum logic [SET_ADDR_W-1:0] {
    SR_TAP_BASE      = 8'd128,
    SR_MAG_GAIN      = 8'd192,
    SR_SQUELCH_LEVEL = 8'd193
  } predist_reg_e;

  localparam sample_t GAIN_RESET    = sample_t'(4096);
  localparam sample_t SQUELCH_RESET = '0;

  // ----------------------------------------
  // unit-vector tables
  // ----------------------------------------
  // entry k is round(UNIT_ONE * cos/sin(2*pi*k/16))
  localparam iq_t UNIT_COS [TAP_COUNT] = '{
    iq_t'(UNIT_ONE),   16'sd15136,  16'sd11585,  16'sd6270,
    16'sd0,            -16'sd6270,  -16'sd11585, -16'sd15136,
    iq_t'(-UNIT_ONE),  -16'sd15136, -16'sd11585, -16'sd6270,
    16'sd0,            16'sd6270,   16'sd11585,  16'sd15136
  };

  localparam iq_t UNIT_SIN [TAP_COUNT] = '{
    16'sd0,            16'sd6270,   16'sd11585,  16'sd15136,
    iq_t'(UNIT_ONE),   16'sd15136,  16'sd11585,  16'sd6270,
    16'sd0,            -16'sd6270,  -16'sd11585, -16'sd15136,
    iq_t'(-UNIT_ONE),  -16'sd15136, -16'sd11585, -16'sd6270
  };

endpackage

`default_nettype wire

// File: hw/predist_settings.sv
/*
 * settings bus decode: holds the magnitude gain and squelch level and turns
 * writes in the tap range into one-cycle tap write strobes for the table
 */
`timescale 1ns/1ps
`default_nettype none

module predist_settings
  import predist_pkg::*;
(
  input  wire logic                  ce_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_set_stb,
  input  wire logic [SET_ADDR_W-1:0] i_set_addr,
  input  wire logic [SET_DATA_W-1:0] i_set_data,
  output sample_t                    o_mag_gain,
  output sample_t                    o_squelch_level,
  output logic                       o_tap_we,
  output logic [TAP_IDX_W-1:0]       o_tap_idx,
  output sample_t                    o_tap_val
);

  logic [SET_ADDR_W-1:0] tap_off;
  logic                  tap_hit;

  // offset from the tap base, only meaningful when tap_hit is set
  assign tap_off = i_set_addr - SR_TAP_BASE;
  assign tap_hit = (i_set_addr >= SR_TAP_BASE) &&
                   (tap_off < SET_ADDR_W'(TAP_COUNT));

  // ----------------------------------------
  // control registers
  // ----------------------------------------
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_mag_gain      <= GAIN_RESET;
      o_squelch_level <= SQUELCH_RESET;
      o_tap_we        <= 1'b0;
    end else begin
      // tap strobe lasts a single cycle
      o_tap_we <= i_set_stb && tap_hit;
      if (i_set_stb) begin
        case (i_set_addr)
          SR_MAG_GAIN:      o_mag_gain      <= i_set_data[SAMPLE_W-1:0];
          SR_SQUELCH_LEVEL: o_squelch_level <= i_set_data[SAMPLE_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // tap index and value ride along with the strobe
  always_ff @(posedge ce_clk) begin
    if (i_set_stb && tap_hit) begin
      o_tap_idx <= tap_off[TAP_IDX_W-1:0];
      o_tap_val <= i_set_data[SAMPLE_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/mag_path.sv
/*
 * magnitude path: squelch, gain and saturate in stage 1, then replace the
 * result with an entry of the loadable 16-tap predistortion table in stage 2
 */
`timescale 1ns/1ps
`default_nettype none

module mag_path
  import predist_pkg::*;
(
  input  wire logic                 ce_clk,
  input  wire logic                 i_rst_n,
  input  wire logic                 i_mag_valid,
  input  sample_t                   i_mag,
  input  sample_t                   i_mag_gain,
  input  sample_t                   i_squelch_level,
  input  wire logic                 i_tap_we,
  input  wire logic [TAP_IDX_W-1:0] i_tap_idx,
  input  sample_t                   i_tap_val,
  input  wire logic                 i_pd_ready,
  output logic                      o_mag_ready,
  output logic                      o_pd_valid,
  output sample_t                   o_pd
);

  sample_t                 taps [TAP_COUNT];

  sample_t                 squelched;
  logic [2*SAMPLE_W-1:0]   product;
  logic [2*SAMPLE_W-1:0]   scaled;
  sample_t                 saturated;

  logic                    s1_valid;
  sample_t                 s1_mag;
  logic                    s1_ready;
  logic                    s2_ready;

  // ----------------------------------------
  // tap table
  // ----------------------------------------
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int k = 0; k < TAP_COUNT; k++) begin
        taps[k] <= '0;
      end
    end else if (i_tap_we) begin
      taps[i_tap_idx] <= i_tap_val;
    end
  end

  // ----------------------------------------
  // stage 1: squelch, gain, saturate
  // ----------------------------------------
  // only magnitudes strictly above the level pass
  assign squelched = (i_mag > i_squelch_level) ? i_mag : '0;
  assign product   = squelched * i_mag_gain;
  assign scaled    = product >> GAIN_FRAC_BITS;
  assign saturated = (|scaled[2*SAMPLE_W-1:SAMPLE_W]) ? '1 : scaled[SAMPLE_W-1:0];

  assign s2_ready    = !o_pd_valid || i_pd_ready;
  assign s1_ready    = !s1_valid || s2_ready;
  assign o_mag_ready = s1_ready;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= i_mag_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (s1_ready && i_mag_valid) begin
      s1_mag <= saturated;
    end
  end

  // ----------------------------------------
  // stage 2: table lookup on the top bits
  // ----------------------------------------
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pd_valid <= 1'b0;
    end else if (s2_ready) begin
      o_pd_valid <= s1_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (s2_ready && s1_valid) begin
      o_pd <= taps[s1_mag[SAMPLE_W-1 -: TAP_IDX_W]];
    end
  end

endmodule

`default_nettype wire

// File: hw/phase_path.sv
/*
 * phase path: maps the top bits of the phase code to a unit vector from the
 * package cos/sin tables, result is registered one cycle after the transfer
 */
`timescale 1ns/1ps
`default_nettype none

module phase_path
  import predist_pkg::*;
(
  input  wire logic ce_clk,
  input  wire logic i_rst_n,
  input  wire logic i_phase_valid,
  input  sample_t   i_phase,
  input  wire logic i_unit_ready,
  output logic      o_phase_ready,
  output logic      o_unit_valid,
  output iq_t       o_unit_i,
  output iq_t       o_unit_q
);

  logic [TAP_IDX_W-1:0] idx;
  iq_t                  look_i;
  iq_t                  look_q;
  logic                 push;
  logic                 pop;

  // second entry holds the next vector while the magnitude side, one
  // stage deeper, catches up; keeps one sample per cycle through the join
  logic                 hold_valid;
  iq_t                  hold_i;
  iq_t                  hold_q;

  assign idx    = i_phase[SAMPLE_W-1 -: TAP_IDX_W];
  assign look_i = UNIT_COS[idx];
  assign look_q = UNIT_SIN[idx];

  assign o_phase_ready = !hold_valid || i_unit_ready;
  assign push          = i_phase_valid && o_phase_ready;
  assign pop           = o_unit_valid && i_unit_ready;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_unit_valid <= 1'b0;
      hold_valid   <= 1'b0;
    end else if (!o_unit_valid || pop) begin
      // head is free, refill from the held entry first
      o_unit_valid <= hold_valid || push;
      hold_valid   <= hold_valid && push;
    end else if (push) begin
      hold_valid <= 1'b1;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (!o_unit_valid || pop) begin
      if (hold_valid) begin
        o_unit_i <= hold_i;
        o_unit_q <= hold_q;
        hold_i   <= look_i;
        hold_q   <= look_q;
      end else begin
        o_unit_i <= look_i;
        o_unit_q <= look_q;
      end
    end else if (push) begin
      hold_i <= look_i;
      hold_q <= look_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/polar_combine.sv
/*
 * joins the predistorted magnitude with the unit vector and registers
 * I = (pd * cos) >>> COMBINE_SHIFT and Q = (pd * sin) >>> COMBINE_SHIFT
 */
`timescale 1ns/1ps
`default_nettype none

module polar_combine
  import predist_pkg::*;
(
  input  wire logic ce_clk,
  input  wire logic i_rst_n,
  input  wire logic i_pd_valid,
  input  sample_t   i_pd,
  input  wire logic i_unit_valid,
  input  iq_t       i_unit_i,
  input  iq_t       i_unit_q,
  input  wire logic i_out_ready,
  output logic      o_pd_ready,
  output logic      o_unit_ready,
  output logic      o_out_valid,
  output iq_t       o_out_i,
  output iq_t       o_out_q
);

  logic                       out_free;
  logic                       join_ok;
  logic signed [SAMPLE_W:0]   pd_s;
  logic signed [2*SAMPLE_W:0] prod_i;
  logic signed [2*SAMPLE_W:0] prod_q;
  logic signed [2*SAMPLE_W:0] shift_i;
  logic signed [2*SAMPLE_W:0] shift_q;

  // ----------------------------------------
  // join
  // ----------------------------------------
  assign out_free     = !o_out_valid || i_out_ready;
  assign join_ok      = i_pd_valid && i_unit_valid && out_free;
  assign o_pd_ready   = join_ok;
  assign o_unit_ready = join_ok;

  // ----------------------------------------
  // scale the unit vector
  // ----------------------------------------
  // magnitude is unsigned, give it a zero sign bit
  assign pd_s    = $signed({1'b0, i_pd});
  assign prod_i  = pd_s * i_unit_i;
  assign prod_q  = pd_s * i_unit_q;
  // floor division, result stays within 16 bits
  assign shift_i = prod_i >>> COMBINE_SHIFT;
  assign shift_q = prod_q >>> COMBINE_SHIFT;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_out_valid <= 1'b0;
    end else if (out_free) begin
      o_out_valid <= i_pd_valid && i_unit_valid;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (join_ok) begin
      o_out_i <= shift_i[SAMPLE_W-1:0];
      o_out_q <= shift_q[SAMPLE_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/predistorter_top.sv
/*
 * polar amplitude predistorter: forks each input sample into the magnitude
 * and phase paths and combines them into signed I/Q
 */
`timescale 1ns/1ps
`default_nettype none

module predistorter_top
  import predist_pkg::*;
(
  input  wire logic                  ce_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_set_stb,
  input  wire logic [SET_ADDR_W-1:0] i_set_addr,
  input  wire logic [SET_DATA_W-1:0] i_set_data,
  input  wire logic                  i_in_valid,
  input  sample_t                    i_in_mag,
  input  sample_t                    i_in_phase,
  input  wire logic                  i_out_ready,
  output logic                       o_in_ready,
  output logic                       o_out_valid,
  output iq_t                        o_out_i,
  output iq_t                        o_out_q
);

  sample_t              mag_gain;
  sample_t              squelch_level;
  logic                 tap_we;
  logic [TAP_IDX_W-1:0] tap_idx;
  sample_t              tap_val;

  logic                 mag_valid;
  logic                 mag_ready;
  logic                 phase_valid;
  logic                 phase_ready;

  logic                 pd_valid;
  logic                 pd_ready;
  sample_t              pd;
  logic                 unit_valid;
  logic                 unit_ready;
  iq_t                  unit_i;
  iq_t                  unit_q;

  // ----------------------------------------
  // input fork
  // ----------------------------------------
  // each side only sees valid when the other can take the sample too
  assign o_in_ready  = mag_ready && phase_ready;
  assign mag_valid   = i_in_valid && phase_ready;
  assign phase_valid = i_in_valid && mag_ready;

  predist_settings u_settings (
    .ce_clk          (ce_clk),
    .i_rst_n         (i_rst_n),
    .i_set_stb       (i_set_stb),
    .i_set_addr      (i_set_addr),
    .i_set_data      (i_set_data),
    .o_mag_gain      (mag_gain),
    .o_squelch_level (squelch_level),
    .o_tap_we        (tap_we),
    .o_tap_idx       (tap_idx),
    .o_tap_val       (tap_val)
  );

  mag_path u_mag_path (
    .ce_clk          (ce_clk),
    .i_rst_n         (i_rst_n),
    .i_mag_valid     (mag_valid),
    .i_mag           (i_in_mag),
    .i_mag_gain      (mag_gain),
    .i_squelch_level (squelch_level),
    .i_tap_we        (tap_we),
    .i_tap_idx       (tap_idx),
    .i_tap_val       (tap_val),
    .i_pd_ready      (pd_ready),
    .o_mag_ready     (mag_ready),
    .o_pd_valid      (pd_valid),
    .o_pd            (pd)
  );

  phase_path u_phase_path (
    .ce_clk        (ce_clk),
    .i_rst_n       (i_rst_n),
    .i_phase_valid (phase_valid),
    .i_phase       (i_in_phase),
    .i_unit_ready  (unit_ready),
    .o_phase_ready (phase_ready),
    .o_unit_valid  (unit_valid),
    .o_unit_i      (unit_i),
    .o_unit_q      (unit_q)
  );

  polar_combine u_combine (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_pd_valid   (pd_valid),
    .i_pd         (pd),
    .i_unit_valid (unit_valid),
    .i_unit_i     (unit_i),
    .i_unit_q     (unit_q),
    .i_out_ready  (i_out_ready),
    .o_pd_ready   (pd_ready),
    .o_unit_ready (unit_ready),
    .o_out_valid  (o_out_valid),
    .o_out_i      (o_out_i),
    .o_out_q      (o_out_q)
  );

endmodule

`default_nettype wire

// File: testbench/predistorter_checker.sv
/*
 * handshake assertions for the predistorter top level, attached with bind
 * from the testbench
 */
`timescale 1ns/1ps
`default_nettype none

module predistorter_checker
  import predist_pkg::*;
(
  input wire logic ce_clk,
  input wire logic i_rst_n,
  input wire logic i_in_valid,
  input wire logic i_in_ready,
  input wire logic i_out_ready,
  input wire logic i_out_valid,
  input iq_t       i_out_i,
  input iq_t       i_out_q
);

  // no output while reset is held
  a_reset_quiet: assert property (@(posedge ce_clk) !i_rst_n |-> !i_out_valid)
    else $error("output valid high during reset");

  // ----------------------------------------
  // output stream
  // ----------------------------------------
  a_valid_held: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    i_out_valid && !i_out_ready |=> i_out_valid)
    else $error("output valid dropped before it was accepted");

  a_data_held: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    i_out_valid && !i_out_ready |=> $stable(i_out_i) && $stable(i_out_q))
    else $error("output I/Q changed while stalled");

  // ----------------------------------------
  // input side
  // ----------------------------------------
  // a refused sample means every stage is full behind a stalled output
  a_in_stall: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    i_in_valid && !i_in_ready |-> i_out_valid && !i_out_ready)
    else $error("input refused while the output was not stalled");

endmodule

`default_nettype wire

// File: testbench/tb_predistorter.sv
/*
 * testbench for the polar predistorter: programs the settings, streams
 * samples and checks every I/Q output in order against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_predistorter;
  import predist_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                  ce_clk;
  logic                  i_rst_n;
  logic                  i_set_stb;
  logic [SET_ADDR_W-1:0] i_set_addr;
  logic [SET_DATA_W-1:0] i_set_data;
  logic                  i_in_valid;
  sample_t               i_in_mag;
  sample_t               i_in_phase;
  logic                  i_out_ready;
  logic                  o_in_ready;
  logic                  o_out_valid;
  iq_t                   o_out_i;
  iq_t                   o_out_q;

  // reference model state, mirrors what was written over the settings bus
  sample_t               model_taps [TAP_COUNT];
  sample_t               model_gain;
  sample_t               model_squelch;
  logic [31:0]           exp_q [$];

  integer                seed;
  logic                  rand_ready;
  string                 test_name;
  int                    checks;
  int                    errors;
  int                    test_checks;
  int                    test_errors;
  logic                  prev_stall;
  iq_t                   prev_i;
  iq_t                   prev_q;

  predistorter_top dut0 (.*);

  bind predistorter_top predistorter_checker chk0 (
    .ce_clk        (ce_clk),
    .i_rst_n       (i_rst_n),
    .i_in_valid    (i_in_valid),
    .i_in_ready    (o_in_ready),
    .i_out_ready   (i_out_ready),
    .i_out_valid   (o_out_valid),
    .i_out_i       (o_out_i),
    .i_out_q       (o_out_q)
  );

  always #20 ce_clk = ~ce_clk;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // squelch, gain with 12 fraction bits, cap, tap lookup, then scale the unit vector
  function automatic logic [31:0] model_iq(input sample_t mag, input sample_t phase);
    int unsigned passed;
    int unsigned amp;
    int unsigned pidx;
    longint      tap;
    longint      prod_i;
    longint      prod_q;
    passed = (mag > model_squelch) ? 32'(mag) : 32'd0;
    amp    = (passed * 32'(model_gain)) >> GAIN_FRAC_BITS;
    if (amp > 65535) amp = 65535;
    tap    = longint'(model_taps[amp >> (SAMPLE_W - TAP_IDX_W)]);
    pidx   = 32'(phase) >> (SAMPLE_W - TAP_IDX_W);
    prod_i = tap * longint'(UNIT_COS[pidx]);
    prod_q = tap * longint'(UNIT_SIN[pidx]);
    return {16'(prod_i >>> COMBINE_SHIFT), 16'(prod_q >>> COMBINE_SHIFT)};
  endfunction

  task automatic check_value(input string what, input int exp, input int got);
    checks++;
    assert (exp == got) else begin
      errors++;
      $display("ERR %s %s expected %0d actual %0d", test_name, what, exp, got);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic write_reg(input logic [SET_ADDR_W-1:0] addr, input int data);
    @(negedge ce_clk);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(negedge ce_clk);
    i_set_stb = 1'b0;
    @(negedge ce_clk);
    if (addr == SR_MAG_GAIN) model_gain = sample_t'(data);
    else if (addr == SR_SQUELCH_LEVEL) model_squelch = sample_t'(data);
    else if (addr >= SR_TAP_BASE && addr < SR_TAP_BASE + TAP_COUNT)
      model_taps[addr - SR_TAP_BASE] = sample_t'(data);
  endtask

  // holds the sample until the edge where the DUT accepts it
  task automatic send_sample(input sample_t mag, input sample_t phase);
    int n;
    @(negedge ce_clk);
    i_in_valid = 1'b1;
    i_in_mag   = mag;
    i_in_phase = phase;
    n = 0;
    @(posedge ce_clk);
    while (!o_in_ready) begin
      n++;
      if (n == TIMEOUT_CYCLES) timeout_fail("input handshake");
      @(posedge ce_clk);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = checks;
    test_errors = errors;
  endtask

  // wait for every pending sample, then report the test
  task automatic end_test();
    int n;
    @(negedge ce_clk);
    i_in_valid = 1'b0;
    n = 0;
    while (exp_q.size() != 0) begin
      n++;
      if (n == TIMEOUT_CYCLES) timeout_fail("output drain");
      @(negedge ce_clk);
    end
    $display("test %-14s checks %0d errors %0d", test_name,
             checks - test_checks, errors - test_errors);
  endtask

  always @(negedge ce_clk) begin
    if (rand_ready) i_out_ready = ($random(seed) % 4) != 0;
    else i_out_ready = 1'b1;
  end

  // ----------------------------------------
  // scoreboard
  // ----------------------------------------
  always @(posedge ce_clk) begin : monitor
    logic [31:0] e;
    if (i_rst_n) begin
      if (prev_stall) begin
        check_value("held valid", 1, int'(o_out_valid));
        check_value("held I", int'(prev_i), int'(o_out_i));
        check_value("held Q", int'(prev_q), int'(o_out_q));
      end
      // input may only be refused behind a stalled output
      if (i_in_valid && !o_in_ready)
        check_value("stall cause", 1, int'(o_out_valid && !i_out_ready));
      if (i_in_valid && o_in_ready) exp_q.push_back(model_iq(i_in_mag, i_in_phase));
      if (o_out_valid && i_out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output arrived with no sample pending in test %s", test_name);
        end else begin
          e = exp_q.pop_front();
          check_value("I", int'($signed(e[31:16])), int'(o_out_i));
          check_value("Q", int'($signed(e[15:0])), int'(o_out_q));
        end
      end
    end
    prev_stall = i_rst_n && o_out_valid && !i_out_ready;
    prev_i     = o_out_i;
    prev_q     = o_out_q;
  end

  initial begin
    int k;
    seed       = 33;
    ce_clk     = 1'b0;
    i_rst_n    = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_in_valid = 1'b0;
    i_in_mag   = '0;
    i_in_phase = '0;
    rand_ready = 1'b0;
    i_out_ready = 1'b1;
    checks     = 0;
    errors     = 0;
    prev_stall = 1'b0;
    model_gain    = GAIN_RESET;
    model_squelch = SQUELCH_RESET;
    for (k = 0; k < TAP_COUNT; k++) model_taps[k] = '0;
    #5;
    i_rst_n = 1'b0;
    repeat (8) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst_n = 1'b1;

    start_test("reset_defaults");
    check_value("out_valid", 0, int'(o_out_valid));
    for (k = 0; k < TAP_COUNT; k++) send_sample(sample_t'(k * 4096 + 100), sample_t'(k * 4096));
    end_test();

    start_test("table_phase");
    for (k = 0; k < TAP_COUNT; k++) write_reg(SR_TAP_BASE + k, 1000 + 4000 * k);
    for (k = 0; k < TAP_COUNT; k++)
      send_sample(sample_t'(k * 4096 + 2048), sample_t'(((k * 5) % 16) * 4096 + k));
    end_test();

    start_test("squelch");
    write_reg(SR_SQUELCH_LEVEL, 'h5000);
    send_sample(16'h4fff, 16'h1000);
    send_sample(16'h5000, 16'h3000);
    send_sample(16'h5001, 16'h5000);
    send_sample(16'h8000, 16'hc000);
    end_test();

    // gain of 3.5 pushes the upper half into saturation
    start_test("gain_saturate");
    write_reg(SR_SQUELCH_LEVEL, 0);
    write_reg(SR_MAG_GAIN, 14336);
    send_sample(16'hffff, 16'h2000);
    send_sample(16'h8000, 16'h6000);
    send_sample(16'h3000, 16'h9000);
    send_sample(16'h1000, 16'he000);
    send_sample(16'h0123, 16'h0000);
    end_test();

    start_test("backpressure");
    write_reg(SR_MAG_GAIN, 5000);
    rand_ready = 1'b1;
    for (k = 0; k < 300; k++) begin
      if (($random(seed) % 5) == 0) begin
        @(negedge ce_clk);
        i_in_valid = 1'b0;
      end
      send_sample(sample_t'($random(seed)), sample_t'($random(seed)));
    end
    end_test();
    rand_ready = 1'b0;

    $display("total checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: predistorter.f
hw/predist_pkg.sv
hw/predist_settings.sv
hw/mag_path.sv
hw/phase_path.sv
hw/polar_combine.sv
hw/predistorter_top.sv
testbench/predistorter_checker.sv
testbench/tb_predistorter.sv

// File: Makefile
# Verilator build and run of the predistorter testbench

SRCS := $(shell cat predistorter.f)

obj_dir/Vtb_predistorter: predistorter.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_predistorter -f predistorter.f

run: obj_dir/Vtb_predistorter
	./obj_dir/Vtb_predistorter | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
